/* hdl/bus_pkg.sv */
/*
 * memory bus definitions
 * widths, source ids and the structs of the split read and write channels
 */
`default_nettype none

package bus_pkg;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned BytesPerWord = 8;
  localparam int unsigned ByteOffset   = $clog2(BytesPerWord);

  // one id bit names the requesting cache
  typedef logic [0:0] bus_id_t;
  localparam bus_id_t ID_ICACHE = 1'b0;
  localparam bus_id_t ID_DCACHE = 1'b1;

  // number of beats minus one
  typedef logic [1:0] beat_len_t;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    beat_len_t            len;
    bus_id_t              id;
  } bus_rd_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    bus_id_t              id;
    logic                 last;
  } bus_rd_rsp_t;

  typedef struct packed {
    logic [AddrWidth-1:0]    addr;
    logic [DataWidth-1:0]    data;
    logic [BytesPerWord-1:0] be;
    bus_id_t                 id;
  } bus_wr_req_t;

  typedef struct packed {
    bus_id_t id;
  } bus_wr_rsp_t;

endpackage

`default_nettype wire

/* hdl/cache_msg_pkg.sv */
/*
 * cache message definitions
 * request and return messages exchanged with the instruction and data
 * caches, plus line geometry and adapter buffer depths
 */
`default_nettype none

package cache_msg_pkg;

  // line geometry
  localparam int unsigned LineWords  = 4;
  localparam int unsigned LineWidth  = LineWords * bus_pkg::DataWidth;
  localparam int unsigned LineOffset = $clog2(LineWidth / 8);

  localparam int unsigned TidWidth = 4;
  typedef logic [TidWidth-1:0] tid_t;

  typedef logic [LineWords-1:0][bus_pkg::DataWidth-1:0] line_t;

  // buffer depths
  localparam int unsigned ReqFifoDepth  = 2;
  // outstanding transactions per tid tracker
  localparam int unsigned MetaFifoDepth = 4;

  typedef struct packed {
    logic [bus_pkg::AddrWidth-1:0] paddr;
    logic                          nc;
    tid_t                          tid;
  } icache_req_t;

  typedef enum logic {
    LOAD,
    STORE
  } dcache_req_type_e;

  // size[2] requests a whole line, size[1:0] is the log2 byte count
  typedef struct packed {
    dcache_req_type_e              rtype;
    logic [bus_pkg::AddrWidth-1:0] paddr;
    logic [2:0]                    size;
    logic [bus_pkg::DataWidth-1:0] data;
    tid_t                          tid;
  } dcache_req_t;

  typedef struct packed {
    tid_t  tid;
    line_t line;
  } icache_rtrn_t;

  typedef enum logic {
    LOAD_ACK,
    STORE_ACK
  } dcache_rtrn_type_e;

  typedef struct packed {
    dcache_rtrn_type_e rtype;
    tid_t              tid;
    line_t             line;
  } dcache_rtrn_t;

endpackage

`default_nettype wire

/* hdl/fifo_buf.sv */
/*
 * synchronous FIFO for any payload type
 * circular buffer with an entry count; the fall-through variant passes
 * the input straight to the output while the buffer is empty
 */
`timescale 1ns/10ps
`default_nettype none

module fifo_buf #(
  parameter type         dtype       = logic,
  parameter int unsigned Depth       = 2,
  parameter bit          FallThrough = 1'b0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  dtype                       mem_q [Depth];
  logic [PtrWidth-1:0]        rd_ptr_q, wr_ptr_q;
  logic [$clog2(Depth+1)-1:0] cnt_q;
  logic                       do_push, do_pop, bypass;

  assign full_o  = (cnt_q == Depth);
  assign empty_o = (cnt_q == 0) && !(FallThrough && push_i);
  assign data_o  = (FallThrough && cnt_q == 0) ? data_i : mem_q[rd_ptr_q];

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  // entry that passes straight through never touches the buffer
  assign bypass  = FallThrough && (cnt_q == 0) && do_push && do_pop;

  always_ff @(posedge clk_i) begin : p_ctrl
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (!bypass) begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!do_push && do_pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_mem
    if (do_push && !bypass) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/req_issue.sv */
/*
 * request issue stage
 * round-robin arbitration between the two caches with lock-in, decode
 * into bus reads and writes, and tid pushes into the return trackers
 */
`timescale 1ns/10ps
`default_nettype none

module req_issue (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // request fifo heads
  input  cache_msg_pkg::icache_req_t  icache_head_i,
  input  logic                        icache_avail_i,
  input  cache_msg_pkg::dcache_req_t  dcache_head_i,
  input  logic                        dcache_avail_i,
  // tracker room
  input  logic                        icache_rd_full_i,
  input  logic                        dcache_rd_full_i,
  input  logic                        dcache_wr_full_i,
  output logic                        icache_pop_o,
  output logic                        dcache_pop_o,
  // bus read request
  output logic                        rd_req_o,
  output bus_pkg::bus_rd_req_t        rd_req_data_o,
  input  logic                        rd_gnt_i,
  // bus write request
  output logic                        wr_req_o,
  output bus_pkg::bus_wr_req_t        wr_req_data_o,
  input  logic                        wr_gnt_i,
  // tracker pushes
  output logic                        icache_rd_push_o,
  output logic                        dcache_rd_push_o,
  output logic                        dcache_wr_push_o,
  output cache_msg_pkg::tid_t         push_tid_o
);
  import bus_pkg::*;
  import cache_msg_pkg::*;

  logic [1:0] arb_req;
  bus_id_t    arb_idx, idx_q, prio_q;
  logic       lock_q, sel_vld;
  logic       rd_fire, wr_fire, gnt;

  // aligned accesses only, so the shifted mask never wraps
  function automatic logic [BytesPerWord-1:0] byte_en(input logic [ByteOffset-1:0] off,
                                                      input logic [1:0]            size);
    logic [BytesPerWord-1:0] mask;
    unique case (size)
      2'b00:   mask = 8'h01;
      2'b01:   mask = 8'h03;
      2'b10:   mask = 8'h0f;
      default: mask = 8'hff;
    endcase
    return mask << off;
  endfunction

  //////////////////////////////////////////////////
  // arbiter
  //////////////////////////////////////////////////

  assign arb_req[ID_ICACHE] = icache_avail_i & ~icache_rd_full_i;
  assign arb_req[ID_DCACHE] = dcache_avail_i & ~(dcache_rd_full_i | dcache_wr_full_i);

  // a pending request keeps its source until granted
  always_comb begin : p_arb
    if (lock_q) begin
      arb_idx = idx_q;
    end else if (arb_req[prio_q]) begin
      arb_idx = prio_q;
    end else begin
      arb_idx = ~prio_q;
    end
  end

  assign sel_vld = arb_req[arb_idx];

  always_ff @(posedge clk_i) begin : p_arb_state
    if (!rst_ni) begin
      prio_q <= ID_ICACHE;
      idx_q  <= ID_ICACHE;
      lock_q <= 1'b0;
    end else begin
      idx_q  <= arb_idx;
      lock_q <= sel_vld & ~gnt;
      if (gnt) begin
        prio_q <= ~arb_idx;
      end
    end
  end

  //////////////////////////////////////////////////
  // request decode
  //////////////////////////////////////////////////

  always_comb begin : p_decode
    rd_req_o         = 1'b0;
    wr_req_o         = 1'b0;
    rd_req_data_o.id = arb_idx;

    if (arb_idx == ID_DCACHE) begin
      rd_req_data_o.addr = dcache_head_i.paddr;
      rd_req_data_o.len  = dcache_head_i.size[2] ? beat_len_t'(LineWords - 1) : '0;
    end else begin
      rd_req_data_o.addr = icache_head_i.paddr;
      rd_req_data_o.len  = icache_head_i.nc ? '0 : beat_len_t'(LineWords - 1);
    end

    // line fills start at the line boundary
    if (rd_req_data_o.len != '0) begin
      rd_req_data_o.addr[LineOffset-1:0] = '0;
    end

    if (sel_vld) begin
      if (arb_idx == ID_DCACHE && dcache_head_i.rtype == STORE) begin
        wr_req_o = 1'b1;
      end else begin
        rd_req_o = 1'b1;
      end
    end
  end

  // stores are always single words
  assign wr_req_data_o.addr = dcache_head_i.paddr;
  assign wr_req_data_o.data = dcache_head_i.data;
  assign wr_req_data_o.be   = byte_en(dcache_head_i.paddr[ByteOffset-1:0],
                                      dcache_head_i.size[1:0]);
  assign wr_req_data_o.id   = ID_DCACHE;

  //////////////////////////////////////////////////
  // handoff
  //////////////////////////////////////////////////

  assign rd_fire = rd_req_o & rd_gnt_i;
  assign wr_fire = wr_req_o & wr_gnt_i;
  assign gnt     = rd_fire | wr_fire;

  assign icache_pop_o     = gnt && arb_idx == ID_ICACHE;
  assign dcache_pop_o     = gnt && arb_idx == ID_DCACHE;
  assign icache_rd_push_o = rd_fire && arb_idx == ID_ICACHE;
  assign dcache_rd_push_o = rd_fire && arb_idx == ID_DCACHE;
  assign dcache_wr_push_o = wr_fire;
  assign push_tid_o       = (arb_idx == ID_DCACHE) ? dcache_head_i.tid : icache_head_i.tid;

endmodule

`default_nettype wire

/* hdl/rsp_return.sv */
/*
 * response return stage
 * tracks outstanding tids per source, buffers write responses, collects
 * read beats into cache lines and returns registered messages to the caches
 */
`timescale 1ns/10ps
`default_nettype none

module rsp_return (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // tid trackers
  input  logic                        icache_rd_push_i,
  input  logic                        dcache_rd_push_i,
  input  logic                        dcache_wr_push_i,
  input  cache_msg_pkg::tid_t         push_tid_i,
  output logic                        icache_rd_full_o,
  output logic                        dcache_rd_full_o,
  output logic                        dcache_wr_full_o,
  // bus read response
  input  logic                        rd_valid_i,
  input  bus_pkg::bus_rd_rsp_t        rd_rsp_i,
  // bus write response
  input  logic                        wr_valid_i,
  input  bus_pkg::bus_wr_rsp_t        wr_rsp_i,
  output logic                        wr_ready_o,
  // cache returns
  output logic                        icache_rtrn_vld_o,
  output cache_msg_pkg::icache_rtrn_t icache_rtrn_o,
  output logic                        dcache_rtrn_vld_o,
  output cache_msg_pkg::dcache_rtrn_t dcache_rtrn_o
);
  import bus_pkg::*;
  import cache_msg_pkg::*;

  tid_t        icache_rd_tid, dcache_rd_tid, dcache_wr_tid;
  logic        icache_beat, dcache_beat;
  logic        icache_done, dcache_done;
  logic        wr_full, wr_empty, store_ack;

  logic                 icache_first_q, dcache_first_q;
  logic [LineWidth-1:0] icache_shift_q, dcache_shift_q;
  logic                 icache_vld_q, dcache_vld_q;
  tid_t                 icache_tid_q, dcache_tid_q;
  dcache_rtrn_type_e    dcache_type_q;

  // a lone beat lands in word 0, line beats shift in from the top
  function automatic logic [LineWidth-1:0] shift_in(input logic [LineWidth-1:0] line,
                                                    input logic [DataWidth-1:0] word,
                                                    input logic                 single);
    if (single) begin
      return {line[LineWidth-1:DataWidth], word};
    end
    return {word, line[LineWidth-1:DataWidth]};
  endfunction

  //////////////////////////////////////////////////
  // tid trackers and write response buffer
  //////////////////////////////////////////////////

  fifo_buf #(
    .dtype ( tid_t         ),
    .Depth ( MetaFifoDepth )
  ) i_icache_rd_tid (
    .clk_i   ( clk_i            ),
    .rst_ni  ( rst_ni           ),
    .push_i  ( icache_rd_push_i ),
    .data_i  ( push_tid_i       ),
    .pop_i   ( icache_done      ),
    .data_o  ( icache_rd_tid    ),
    .full_o  ( icache_rd_full_o ),
    .empty_o (                  )
  );

  fifo_buf #(
    .dtype ( tid_t         ),
    .Depth ( MetaFifoDepth )
  ) i_dcache_rd_tid (
    .clk_i   ( clk_i            ),
    .rst_ni  ( rst_ni           ),
    .push_i  ( dcache_rd_push_i ),
    .data_i  ( push_tid_i       ),
    .pop_i   ( dcache_done      ),
    .data_o  ( dcache_rd_tid    ),
    .full_o  ( dcache_rd_full_o ),
    .empty_o (                  )
  );

  fifo_buf #(
    .dtype ( tid_t         ),
    .Depth ( MetaFifoDepth )
  ) i_dcache_wr_tid (
    .clk_i   ( clk_i            ),
    .rst_ni  ( rst_ni           ),
    .push_i  ( dcache_wr_push_i ),
    .data_i  ( push_tid_i       ),
    .pop_i   ( store_ack        ),
    .data_o  ( dcache_wr_tid    ),
    .full_o  ( dcache_wr_full_o ),
    .empty_o (                  )
  );

  fifo_buf #(
    .dtype       ( bus_wr_rsp_t  ),
    .Depth       ( MetaFifoDepth ),
    .FallThrough ( 1'b1          )
  ) i_wr_rsp_fifo (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .push_i  ( wr_valid_i ),
    .data_i  ( wr_rsp_i   ),
    .pop_i   ( store_ack  ),
    .data_o  (            ),
    .full_o  ( wr_full    ),
    .empty_o ( wr_empty   )
  );

  assign wr_ready_o = ~wr_full;

  //////////////////////////////////////////////////
  // response decode
  //////////////////////////////////////////////////

  assign icache_beat = rd_valid_i && rd_rsp_i.id == ID_ICACHE;
  assign dcache_beat = rd_valid_i && rd_rsp_i.id == ID_DCACHE;
  assign icache_done = icache_beat & rd_rsp_i.last;
  assign dcache_done = dcache_beat & rd_rsp_i.last;

  // read beats own the dcache return port, store acks wait a cycle
  assign store_ack = ~wr_empty & ~dcache_beat;

  always_ff @(posedge clk_i) begin : p_ctrl
    if (!rst_ni) begin
      icache_first_q <= 1'b1;
      dcache_first_q <= 1'b1;
      icache_vld_q   <= 1'b0;
      dcache_vld_q   <= 1'b0;
    end else begin
      if (icache_beat) begin
        icache_first_q <= rd_rsp_i.last;
      end
      if (dcache_beat) begin
        dcache_first_q <= rd_rsp_i.last;
      end
      icache_vld_q <= icache_done;
      dcache_vld_q <= dcache_done | store_ack;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (icache_beat) begin
      icache_shift_q <= shift_in(icache_shift_q, rd_rsp_i.data, icache_first_q & rd_rsp_i.last);
    end
    if (dcache_beat) begin
      dcache_shift_q <= shift_in(dcache_shift_q, rd_rsp_i.data, dcache_first_q & rd_rsp_i.last);
    end
    if (icache_done) begin
      icache_tid_q <= icache_rd_tid;
    end
    if (dcache_done) begin
      dcache_tid_q  <= dcache_rd_tid;
      dcache_type_q <= LOAD_ACK;
    end else if (store_ack) begin
      dcache_tid_q  <= dcache_wr_tid;
      dcache_type_q <= STORE_ACK;
    end
  end

  assign icache_rtrn_vld_o   = icache_vld_q;
  assign icache_rtrn_o.tid   = icache_tid_q;
  assign icache_rtrn_o.line  = icache_shift_q;
  assign dcache_rtrn_vld_o   = dcache_vld_q;
  assign dcache_rtrn_o.rtype = dcache_type_q;
  assign dcache_rtrn_o.tid   = dcache_tid_q;
  assign dcache_rtrn_o.line  = dcache_shift_q;

endmodule

`default_nettype wire

/* hdl/cache_bus_adapter.sv */
/*
 * cache to memory bus adapter
 * buffers icache and dcache requests, issues them on the split read and
 * write channels and returns line fills, loads and store acks
 */
`timescale 1ns/10ps
`default_nettype none

module cache_bus_adapter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // icache
  input  logic                        icache_data_req_i,
  output logic                        icache_data_ack_o,
  input  cache_msg_pkg::icache_req_t  icache_data_i,
  output logic                        icache_rtrn_vld_o,
  output cache_msg_pkg::icache_rtrn_t icache_rtrn_o,
  // dcache
  input  logic                        dcache_data_req_i,
  output logic                        dcache_data_ack_o,
  input  cache_msg_pkg::dcache_req_t  dcache_data_i,
  output logic                        dcache_rtrn_vld_o,
  output cache_msg_pkg::dcache_rtrn_t dcache_rtrn_o,
  // bus read channel
  output logic                        rd_req_o,
  output bus_pkg::bus_rd_req_t        rd_req_data_o,
  input  logic                        rd_gnt_i,
  input  logic                        rd_valid_i,
  input  bus_pkg::bus_rd_rsp_t        rd_rsp_i,
  // bus write channel
  output logic                        wr_req_o,
  output bus_pkg::bus_wr_req_t        wr_req_data_o,
  input  logic                        wr_gnt_i,
  input  logic                        wr_valid_i,
  input  bus_pkg::bus_wr_rsp_t        wr_rsp_i,
  output logic                        wr_ready_o
);
  import cache_msg_pkg::*;

  icache_req_t icache_head;
  dcache_req_t dcache_head;
  logic        icache_full, icache_empty, icache_pop;
  logic        dcache_full, dcache_empty, dcache_pop;
  logic        icache_rd_full, dcache_rd_full, dcache_wr_full;
  logic        icache_rd_push, dcache_rd_push, dcache_wr_push;
  tid_t        push_tid;

  assign icache_data_ack_o = icache_data_req_i & ~icache_full;
  assign dcache_data_ack_o = dcache_data_req_i & ~dcache_full;

  fifo_buf #(
    .dtype ( icache_req_t ),
    .Depth ( ReqFifoDepth )
  ) i_icache_req_fifo (
    .clk_i   ( clk_i             ),
    .rst_ni  ( rst_ni            ),
    .push_i  ( icache_data_ack_o ),
    .data_i  ( icache_data_i     ),
    .pop_i   ( icache_pop        ),
    .data_o  ( icache_head       ),
    .full_o  ( icache_full       ),
    .empty_o ( icache_empty      )
  );

  fifo_buf #(
    .dtype ( dcache_req_t ),
    .Depth ( ReqFifoDepth )
  ) i_dcache_req_fifo (
    .clk_i   ( clk_i             ),
    .rst_ni  ( rst_ni            ),
    .push_i  ( dcache_data_ack_o ),
    .data_i  ( dcache_data_i     ),
    .pop_i   ( dcache_pop        ),
    .data_o  ( dcache_head       ),
    .full_o  ( dcache_full       ),
    .empty_o ( dcache_empty      )
  );

  req_issue i_req_issue (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .icache_head_i    ( icache_head    ),
    .icache_avail_i   ( ~icache_empty  ),
    .dcache_head_i    ( dcache_head    ),
    .dcache_avail_i   ( ~dcache_empty  ),
    .icache_rd_full_i ( icache_rd_full ),
    .dcache_rd_full_i ( dcache_rd_full ),
    .dcache_wr_full_i ( dcache_wr_full ),
    .icache_pop_o     ( icache_pop     ),
    .dcache_pop_o     ( dcache_pop     ),
    .rd_req_o         ( rd_req_o       ),
    .rd_req_data_o    ( rd_req_data_o  ),
    .rd_gnt_i         ( rd_gnt_i       ),
    .wr_req_o         ( wr_req_o       ),
    .wr_req_data_o    ( wr_req_data_o  ),
    .wr_gnt_i         ( wr_gnt_i       ),
    .icache_rd_push_o ( icache_rd_push ),
    .dcache_rd_push_o ( dcache_rd_push ),
    .dcache_wr_push_o ( dcache_wr_push ),
    .push_tid_o       ( push_tid       )
  );

  rsp_return i_rsp_return (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .icache_rd_push_i  ( icache_rd_push    ),
    .dcache_rd_push_i  ( dcache_rd_push    ),
    .dcache_wr_push_i  ( dcache_wr_push    ),
    .push_tid_i        ( push_tid          ),
    .icache_rd_full_o  ( icache_rd_full    ),
    .dcache_rd_full_o  ( dcache_rd_full    ),
    .dcache_wr_full_o  ( dcache_wr_full    ),
    .rd_valid_i        ( rd_valid_i        ),
    .rd_rsp_i          ( rd_rsp_i          ),
    .wr_valid_i        ( wr_valid_i        ),
    .wr_rsp_i          ( wr_rsp_i          ),
    .wr_ready_o        ( wr_ready_o        ),
    .icache_rtrn_vld_o ( icache_rtrn_vld_o ),
    .icache_rtrn_o     ( icache_rtrn_o     ),
    .dcache_rtrn_vld_o ( dcache_rtrn_vld_o ),
    .dcache_rtrn_o     ( dcache_rtrn_o     )
  );

endmodule

`default_nettype wire

/* dv/tb_cache_bus_adapter.sv */
/*
 * directed testbench for the cache to memory bus adapter
 * a memory model serves the split read and write channels, and each
 * test drives cache requests and checks the returned messages
 */
`timescale 1ns/10ps
`default_nettype none

module tb_cache_bus_adapter;
  import bus_pkg::*;
  import cache_msg_pkg::*;

  localparam int unsigned ClkPeriod     = 100;
  localparam int unsigned DriveDelay    = 1;
  localparam int unsigned ResetCycles   = 3;
  localparam int unsigned TimeoutCycles = 400;
  localparam int unsigned MemWords      = 64;
  localparam logic [15:0] Seed          = 16'd64198;

  logic         clk_i, rst_ni;
  logic         icache_data_req_i, icache_data_ack_o, icache_rtrn_vld_o;
  icache_req_t  icache_data_i;
  icache_rtrn_t icache_rtrn_o;
  logic         dcache_data_req_i, dcache_data_ack_o, dcache_rtrn_vld_o;
  dcache_req_t  dcache_data_i;
  dcache_rtrn_t dcache_rtrn_o;
  logic         rd_req_o, rd_gnt_i, rd_valid_i;
  bus_rd_req_t  rd_req_data_o;
  bus_rd_rsp_t  rd_rsp_i;
  logic         wr_req_o, wr_gnt_i, wr_valid_i, wr_ready_o;
  bus_wr_req_t  wr_req_data_o;
  bus_wr_rsp_t  wr_rsp_i;

  // memory model contents and the expected image kept by the tests
  logic [DataWidth-1:0] mem [MemWords];
  logic [DataWidth-1:0] exp_mem [MemWords];
  bus_rd_req_t          rd_q [$];
  bus_id_t              wr_q [$];
  int                   rd_beat, rd_wait, wr_wait;
  int                   gnt_gap = 1;
  logic                 gnt_en = 1'b1;
  int                   cycle_cnt = 0;

  // expected returns in issue order
  tid_t              exp_ic_tid [$];
  line_t             exp_ic_line [$];
  int                exp_ic_words [$];
  dcache_rtrn_type_e exp_dc_type [$];
  tid_t              exp_dc_tid [$];
  line_t             exp_dc_line [$];
  int                exp_dc_words [$];

  cache_bus_adapter i_dut (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .icache_data_req_i ( icache_data_req_i ),
    .icache_data_ack_o ( icache_data_ack_o ),
    .icache_data_i     ( icache_data_i     ),
    .icache_rtrn_vld_o ( icache_rtrn_vld_o ),
    .icache_rtrn_o     ( icache_rtrn_o     ),
    .dcache_data_req_i ( dcache_data_req_i ),
    .dcache_data_ack_o ( dcache_data_ack_o ),
    .dcache_data_i     ( dcache_data_i     ),
    .dcache_rtrn_vld_o ( dcache_rtrn_vld_o ),
    .dcache_rtrn_o     ( dcache_rtrn_o     ),
    .rd_req_o          ( rd_req_o          ),
    .rd_req_data_o     ( rd_req_data_o     ),
    .rd_gnt_i          ( rd_gnt_i          ),
    .rd_valid_i        ( rd_valid_i        ),
    .rd_rsp_i          ( rd_rsp_i          ),
    .wr_req_o          ( wr_req_o          ),
    .wr_req_data_o     ( wr_req_data_o     ),
    .wr_gnt_i          ( wr_gnt_i          ),
    .wr_valid_i        ( wr_valid_i        ),
    .wr_rsp_i          ( wr_rsp_i          ),
    .wr_ready_o        ( wr_ready_o        )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input string name, input logic [LineWidth-1:0] act,
                             input logic [LineWidth-1:0] exp);
    if (act !== exp) begin
      report_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, act, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : p_bus
    bus_rd_req_t cur;
    int          idx;
    if (!rst_ni) begin
      rd_q.delete();
      wr_q.delete();
      rd_beat = 0;
      rd_wait = 0;
      wr_wait = 0;
    end else begin
      if (rd_valid_i) begin
        if (rd_rsp_i.last) begin
          void'(rd_q.pop_front());
          rd_beat = 0;
        end else begin
          rd_beat++;
        end
      end
      if (wr_valid_i && wr_ready_o) begin
        void'(wr_q.pop_front());
      end
      if (rd_req_o && rd_gnt_i) begin
        rd_q.push_back(rd_req_data_o);
        rd_wait = 0;
      end else if (rd_req_o) begin
        rd_wait++;
      end
      if (wr_req_o && wr_gnt_i) begin
        idx = wr_req_data_o.addr[8:3];
        for (int b = 0; b < BytesPerWord; b++) begin
          if (wr_req_data_o.be[b]) begin
            mem[idx][8*b +: 8] = wr_req_data_o.data[8*b +: 8];
          end
        end
        wr_q.push_back(wr_req_data_o.id);
        wr_wait = 0;
      end else if (wr_req_o) begin
        wr_wait++;
      end
    end
    #DriveDelay;
    rd_gnt_i   = rst_ni && gnt_en && rd_wait >= gnt_gap;
    wr_gnt_i   = rst_ni && gnt_en && wr_wait >= gnt_gap;
    rd_valid_i = rd_q.size() != 0;
    rd_rsp_i   = '0;
    if (rd_valid_i) begin
      cur           = rd_q[0];
      rd_rsp_i.data = mem[cur.addr[8:3] + rd_beat];
      rd_rsp_i.id   = cur.id;
      rd_rsp_i.last = (rd_beat == cur.len);
    end
    wr_valid_i  = wr_q.size() != 0;
    wr_rsp_i.id = wr_valid_i ? wr_q[0] : ID_ICACHE;
  end

  //////////////////////////////////////////////////
  // return monitor and timeout
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : p_monitor
    line_t line;
    int    words;
    if (rst_ni && icache_rtrn_vld_o) begin
      if (exp_ic_tid.size() == 0) begin
        report_failure("icache received a return that was never requested");
      end
      check_equal("icache_rtrn_o.tid", icache_rtrn_o.tid, exp_ic_tid.pop_front());
      line  = exp_ic_line.pop_front();
      words = exp_ic_words.pop_front();
      for (int k = 0; k < words; k++) begin
        check_equal($sformatf("icache_rtrn_o.line[%0d]", k), icache_rtrn_o.line[k], line[k]);
      end
    end
    if (rst_ni && dcache_rtrn_vld_o) begin
      if (exp_dc_tid.size() == 0) begin
        report_failure("dcache received a return that was never requested");
      end
      check_equal("dcache_rtrn_o.rtype", dcache_rtrn_o.rtype, exp_dc_type.pop_front());
      check_equal("dcache_rtrn_o.tid", dcache_rtrn_o.tid, exp_dc_tid.pop_front());
      line  = exp_dc_line.pop_front();
      words = exp_dc_words.pop_front();
      for (int k = 0; k < words; k++) begin
        check_equal($sformatf("dcache_rtrn_o.line[%0d]", k), dcache_rtrn_o.line[k], line[k]);
      end
    end
  end

  always @(posedge clk_i) begin : p_timeout
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      report_failure($sformatf("simulation did not finish within %0d cycles", TimeoutCycles));
    end
  end

  //////////////////////////////////////////////////
  // cache side drivers
  //////////////////////////////////////////////////

  // every task starts and ends at the drive point after a rising edge
  task automatic send_icache(input logic [31:0] paddr, input logic nc, input tid_t tid);
    line_t line;
    int    idx;
    icache_data_req_i = 1'b1;
    icache_data_i     = '{paddr: paddr, nc: nc, tid: tid};
    @(posedge clk_i);
    while (!icache_data_ack_o) begin
      @(posedge clk_i);
    end
    idx  = paddr[8:3];
    line = '0;
    if (nc) begin
      line[0] = exp_mem[idx];
    end else begin
      for (int k = 0; k < LineWords; k++) begin
        line[k] = exp_mem[(idx & ~3) + k];
      end
    end
    exp_ic_tid.push_back(tid);
    exp_ic_line.push_back(line);
    exp_ic_words.push_back(nc ? 1 : LineWords);
    #DriveDelay;
    icache_data_req_i = 1'b0;
  endtask

  task automatic send_dcache(input dcache_req_type_e rtype, input logic [31:0] paddr,
                             input logic [2:0] size, input logic [63:0] data,
                             input tid_t tid);
    line_t line;
    int    idx;
    int    off;
    int    words;
    dcache_data_req_i = 1'b1;
    dcache_data_i     = '{rtype: rtype, paddr: paddr, size: size, data: data, tid: tid};
    @(posedge clk_i);
    while (!dcache_data_ack_o) begin
      @(posedge clk_i);
    end
    idx   = paddr[8:3];
    off   = paddr[2:0];
    line  = '0;
    words = 0;
    if (rtype == STORE) begin
      // size-many bytes starting at the byte offset
      for (int b = off; b < off + (1 << size[1:0]); b++) begin
        exp_mem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end else if (size[2]) begin
      words = LineWords;
      for (int k = 0; k < LineWords; k++) begin
        line[k] = exp_mem[(idx & ~3) + k];
      end
    end else begin
      words   = 1;
      line[0] = exp_mem[idx];
    end
    exp_dc_type.push_back(rtype == STORE ? STORE_ACK : LOAD_ACK);
    exp_dc_tid.push_back(tid);
    exp_dc_line.push_back(line);
    exp_dc_words.push_back(words);
    #DriveDelay;
    dcache_data_req_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_ic_tid.size() != 0 || exp_dc_tid.size() != 0) begin
      @(posedge clk_i);
    end
    // a few more cycles so that a duplicate return would be seen
    repeat (4) @(posedge clk_i);
    #DriveDelay;
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic reset_values();
    @(posedge clk_i);
    check_equal("icache_rtrn_vld_o", icache_rtrn_vld_o, 1'b0);
    check_equal("dcache_rtrn_vld_o", dcache_rtrn_vld_o, 1'b0);
    check_equal("icache_data_ack_o", icache_data_ack_o, 1'b0);
    check_equal("dcache_data_ack_o", dcache_data_ack_o, 1'b0);
    check_equal("rd_req_o", rd_req_o, 1'b0);
    check_equal("wr_req_o", wr_req_o, 1'b0);
    check_equal("wr_ready_o", wr_ready_o, 1'b1);
    #DriveDelay;
  endtask

  task automatic icache_fill();
    send_icache(32'h0000_0048, 1'b0, 4'h1);
    wait_idle();
    send_icache(32'h0000_0070, 1'b1, 4'h2);
    wait_idle();
  endtask

  task automatic store_then_load();
    send_dcache(STORE, 32'h0000_0043, 3'b000, 64'h1122_3344_5566_7788, 4'h3);
    wait_idle();
    send_dcache(LOAD, 32'h0000_0040, 3'b011, '0, 4'h4);
    wait_idle();
    send_dcache(STORE, 32'h0000_0052, 3'b001, 64'hdead_beef_cafe_f00d, 4'h5);
    wait_idle();
    send_dcache(LOAD, 32'h0000_0050, 3'b011, '0, 4'h6);
    wait_idle();
  endtask

  task automatic mixed_traffic();
    @(posedge clk_i);
    gnt_gap = 0;
    #DriveDelay;
    fork
      begin
        send_icache(32'h0000_0100, 1'b0, 4'h7);
        send_icache(32'h0000_0120, 1'b1, 4'h8);
        send_icache(32'h0000_0140, 1'b0, 4'h9);
      end
      begin
        send_dcache(LOAD, 32'h0000_0080, 3'b100, '0, 4'ha);
        send_dcache(LOAD, 32'h0000_0098, 3'b011, '0, 4'hb);
        send_dcache(LOAD, 32'h0000_00c0, 3'b100, '0, 4'hc);
      end
    join
    wait_idle();
    @(posedge clk_i);
    gnt_gap = 1;
    #DriveDelay;
  endtask

  task automatic grant_stall();
    @(posedge clk_i);
    gnt_en = 1'b0;
    #DriveDelay;
    send_icache(32'h0000_0180, 1'b0, 4'hd);
    send_icache(32'h0000_01a0, 1'b0, 4'he);
    icache_data_req_i = 1'b1;
    icache_data_i     = '{paddr: 32'h0000_01c8, nc: 1'b1, tid: 4'hf};
    @(posedge clk_i);
    // both request slots are taken
    check_equal("icache_data_ack_o", icache_data_ack_o, 1'b0);
    gnt_en = 1'b1;
    #DriveDelay;
    send_icache(32'h0000_01c8, 1'b1, 4'hf);
    wait_idle();
  endtask

  initial begin : p_main
    logic [15:0]          lfsr;
    logic [DataWidth-1:0] word;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    icache_data_req_i = 1'b0;
    icache_data_i     = '0;
    dcache_data_req_i = 1'b0;
    dcache_data_i     = '0;
    rd_gnt_i          = 1'b0;
    rd_valid_i        = 1'b0;
    rd_rsp_i          = '0;
    wr_gnt_i          = 1'b0;
    wr_valid_i        = 1'b0;
    wr_rsp_i          = '0;
    lfsr              = Seed;
    for (int i = 0; i < MemWords; i++) begin
      for (int b = 0; b < DataWidth; b++) begin
        lfsr    = lfsr_next(lfsr);
        word[b] = lfsr[0];
      end
      mem[i]     = word ^ DataWidth'(i);
      exp_mem[i] = mem[i];
    end
    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
    reset_values();
    icache_fill();
    store_then_load();
    mixed_traffic();
    grant_stall();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hdl/bus_pkg.sv
hdl/cache_msg_pkg.sv
hdl/fifo_buf.sv
hdl/req_issue.sv
hdl/rsp_return.sv
hdl/cache_bus_adapter.sv
dv/tb_cache_bus_adapter.sv

/* Bender.yml */
package:
  name: cache_bus_adapter

sources:
  - hdl/bus_pkg.sv
  - hdl/cache_msg_pkg.sv
  - hdl/fifo_buf.sv
  - hdl/req_issue.sv
  - hdl/rsp_return.sv
  - hdl/cache_bus_adapter.sv
  - target: test
    files:
      - dv/tb_cache_bus_adapter.sv
